/* source/exec_pkg.sv */
package exec_pkg;

  // datapath width, fixed by the ALU sign handling and the struct layouts
  localparam int XLEN = 32;

  // operations of the shared ALU
  typedef enum logic [4:0] {
    ALU_ADD   = 5'd0,
    ALU_SUB   = 5'd1,
    ALU_AND   = 5'd2,
    ALU_OR    = 5'd3,
    ALU_XOR   = 5'd4,
    ALU_SLL   = 5'd5,
    ALU_SRL   = 5'd6,
    ALU_SRA   = 5'd7,
    ALU_PASSB = 5'd8,
    ALU_ADD4A = 5'd9,
    ALU_EQ    = 5'd10,
    ALU_NEQ   = 5'd11,
    ALU_SLT   = 5'd12,
    ALU_SGTE  = 5'd13,
    ALU_SLTU  = 5'd14,
    ALU_SGTEU = 5'd15
  } alu_op_e;

  // instruction class handled by int_exec
  typedef enum logic [1:0] {
    KIND_OP     = 2'd0,
    KIND_OP_IMM = 2'd1,
    KIND_LUI    = 2'd2
  } exec_kind_e;

  // arithmetic request, b is rs2 or the already extended immediate
  typedef struct packed {
    exec_kind_e      kind;
    logic [2:0]      funct3;
    logic            alt;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } exec_req_t;

  typedef logic [XLEN-1:0] exec_rsp_t;

  // conditional branch request
  typedef struct packed {
    logic [2:0]      funct3;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
  } branch_req_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] next_pc;
  } branch_rsp_t;

  // one client's command on the shared ALU bus
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } alu_cmd_t;

endpackage

/* source/alu.sv */
`timescale 1ns/1ns

module alu (
  input  logic [exec_pkg::XLEN-1:0] i_a,
  input  logic [exec_pkg::XLEN-1:0] i_b,
  input  exec_pkg::alu_op_e         i_op,
  output logic [exec_pkg::XLEN-1:0] o_result
);
  import exec_pkg::*;

  logic [XLEN-1:0] b_in;
  logic            carry_in;
  logic [XLEN-1:0] sum;
  logic            carry_out;
  logic [XLEN-1:0] xor_ab;
  logic            is_eq;
  logic            lt_signed;

  // one adder serves add, sub, add-4 and every magnitude compare
  always_comb begin
    case (i_op)
      ALU_SUB, ALU_SLT, ALU_SGTE, ALU_SLTU, ALU_SGTEU: begin
        b_in     = ~i_b;
        carry_in = 1'b1;
      end
      ALU_ADD4A: begin
        b_in     = XLEN'(4);
        carry_in = 1'b0;
      end
      default: begin
        b_in     = i_b;
        carry_in = 1'b0;
      end
    endcase
  end

  assign {carry_out, sum} = {1'b0, i_a} + {1'b0, b_in} + (XLEN + 1)'(carry_in);

  assign xor_ab = i_a ^ i_b;
  assign is_eq  = ~|xor_ab;

  // differing signs decide directly, equal signs look at the difference
  always_comb begin
    case ({i_a[XLEN-1], i_b[XLEN-1]})
      2'b01:   lt_signed = 1'b0;
      2'b10:   lt_signed = 1'b1;
      default: lt_signed = sum[XLEN-1];
    endcase
  end

  // carry out of a + ~b + 1 is set when a >= b unsigned
  always_comb begin
    case (i_op)
      ALU_ADD,
      ALU_SUB,
      ALU_ADD4A: o_result = sum;
      ALU_AND:   o_result = i_a & i_b;
      ALU_OR:    o_result = i_a | i_b;
      ALU_XOR:   o_result = xor_ab;
      ALU_SLL:   o_result = i_a << i_b;
      ALU_SRL:   o_result = i_a >> i_b;
      ALU_SRA:   o_result = $signed(i_a) >>> i_b;
      ALU_PASSB: o_result = i_b;
      ALU_EQ:    o_result = {{(XLEN-1){1'b0}}, is_eq};
      ALU_NEQ:   o_result = {{(XLEN-1){1'b0}}, ~is_eq};
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SGTE:  o_result = {{(XLEN-1){1'b0}}, ~lt_signed};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, ~carry_out};
      ALU_SGTEU: o_result = {{(XLEN-1){1'b0}}, carry_out};
      default:   o_result = sum;
    endcase
  end

endmodule

/* source/alu_arbiter.sv */
`timescale 1ns/1ns

module alu_arbiter #(
  parameter int N_CLIENTS = 2
) (
  input  logic                                  i_clk,
  input  logic                                  i_arst_n,
  input  logic [N_CLIENTS-1:0]                  i_req,
  input  exec_pkg::alu_cmd_t [N_CLIENTS-1:0]    i_cmd,
  output logic [N_CLIENTS-1:0]                  o_done,
  output logic [exec_pkg::XLEN-1:0]             o_result,
  output exec_pkg::alu_cmd_t                    o_alu_cmd,
  input  logic [exec_pkg::XLEN-1:0]             i_alu_result
);
  import exec_pkg::*;

  localparam int IDX_W = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1;

  logic [IDX_W-1:0]     ptr_q;
  logic [IDX_W-1:0]     grant_idx;
  logic                 grant_valid;
  logic [N_CLIENTS-1:0] eligible;

  // a client whose done goes out this cycle still shows its old request
  assign eligible = i_req & ~o_done;

  // walk from the lowest priority up so the pointer position wins last
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = ptr_q;
    for (int k = N_CLIENTS - 1; k >= 0; k--) begin
      idx = (int'(ptr_q) + k) % N_CLIENTS;
      if (eligible[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = IDX_W'(idx);
      end
    end
  end

  assign o_alu_cmd = i_cmd[grant_idx];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ptr_q  <= '0;
      o_done <= '0;
    end else begin
      o_done <= '0;
      if (grant_valid) begin
        o_done[grant_idx] <= 1'b1;
        // granted client drops to the lowest priority
        if (int'(grant_idx) == N_CLIENTS - 1)
          ptr_q <= '0;
        else
          ptr_q <= grant_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_result <= i_alu_result;
  end

endmodule

/* source/req_ack_port.sv */
`timescale 1ns/1ns

module req_ack_port #(
  parameter type payload_t = logic [31:0],
  parameter type result_t  = logic [31:0]
) (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_req,
  input  payload_t i_payload,
  output logic     o_ack,
  output result_t  o_result,
  output logic     o_start,
  output payload_t o_payload,
  input  logic     i_done,
  input  result_t  i_result
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } state_e;

  state_e state_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
      o_start <= 1'b0;
    end else begin
      o_start <= 1'b0;
      case (state_q)
        // req is only seen high here after a full return phase
        ST_IDLE: if (i_req) begin
          state_q <= ST_BUSY;
          o_start <= 1'b1;
        end
        ST_BUSY: if (i_done) state_q <= ST_ACK;
        ST_ACK:  if (!i_req) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // payload stays put until the next request, the unit reads it throughout
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_req)
      o_payload <= i_payload;
    if (state_q == ST_BUSY && i_done)
      o_result <= i_result;
  end

  assign o_ack = (state_q == ST_ACK);

endmodule

/* source/int_exec.sv */
`timescale 1ns/1ns

module int_exec (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_start,
  input  exec_pkg::exec_req_t       i_req,
  output logic                      o_done,
  output exec_pkg::exec_rsp_t       o_rsp,
  output logic                      o_alu_req,
  output exec_pkg::alu_cmd_t        o_alu_cmd,
  input  logic                      i_alu_done,
  input  logic [exec_pkg::XLEN-1:0] i_alu_result
);
  import exec_pkg::*;

  alu_op_e         op;
  logic            is_shift;
  logic [XLEN-1:0] b_eff;

  // funct3 decode, alt only matters for register add and right shifts
  always_comb begin
    if (i_req.kind == KIND_LUI) begin
      op = ALU_PASSB;
    end else begin
      case (i_req.funct3)
        3'd0:    op = (i_req.alt && i_req.kind == KIND_OP) ? ALU_SUB : ALU_ADD;
        3'd1:    op = ALU_SLL;
        3'd2:    op = ALU_SLT;
        3'd3:    op = ALU_SLTU;
        3'd4:    op = ALU_XOR;
        3'd5:    op = i_req.alt ? ALU_SRA : ALU_SRL;
        3'd6:    op = ALU_OR;
        default: op = ALU_AND;
      endcase
    end
  end

  // the ALU shifts by the whole of b, so trim it to a 5 bit amount here
  assign is_shift = (op == ALU_SLL) || (op == ALU_SRL) || (op == ALU_SRA);
  assign b_eff    = is_shift ? {{(XLEN-5){1'b0}}, i_req.b[4:0]} : i_req.b;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n)
      o_alu_req <= 1'b0;
    else if (i_start)
      o_alu_req <= 1'b1;
    else if (i_alu_done)
      o_alu_req <= 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (i_start)
      o_alu_cmd <= '{op: op, a: i_req.a, b: b_eff};
  end

  // arbiter result is already registered, pass it on with done
  assign o_done = i_alu_done & o_alu_req;
  assign o_rsp  = i_alu_result;

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_start,
  input  exec_pkg::branch_req_t     i_req,
  output logic                      o_done,
  output exec_pkg::branch_rsp_t     o_rsp,
  output logic                      o_alu_req,
  output exec_pkg::alu_cmd_t        o_alu_cmd,
  input  logic                      i_alu_done,
  input  logic [exec_pkg::XLEN-1:0] i_alu_result
);
  import exec_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMP,
    ST_TGT
  } state_e;

  state_e  state_q;
  alu_op_e cmp_op;
  logic    cond_valid;
  logic    taken;
  logic    taken_q;

  always_comb begin
    case (i_req.funct3)
      3'd0:    cmp_op = ALU_EQ;
      3'd1:    cmp_op = ALU_NEQ;
      3'd4:    cmp_op = ALU_SLT;
      3'd5:    cmp_op = ALU_SGTE;
      3'd6:    cmp_op = ALU_SLTU;
      3'd7:    cmp_op = ALU_SGTEU;
      default: cmp_op = ALU_EQ;
    endcase
  end

  // funct3 2 and 3 are no branch, they still run both passes
  assign cond_valid = (i_req.funct3[2:1] != 2'b01);
  assign taken      = i_alu_result[0] & cond_valid;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (i_start) state_q <= ST_CMP;
        ST_CMP:  if (i_alu_done) state_q <= ST_TGT;
        ST_TGT:  if (i_alu_done) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // pc and imm come from the port copy, which holds until the next request
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_start) begin
      o_alu_cmd <= '{op: cmp_op, a: i_req.rs1, b: i_req.rs2};
    end else if (state_q == ST_CMP && i_alu_done) begin
      taken_q <= taken;
      if (taken)
        o_alu_cmd <= '{op: ALU_ADD, a: i_req.pc, b: i_req.imm};
      else
        o_alu_cmd <= '{op: ALU_ADD4A, a: i_req.pc, b: '0};
    end
  end

  // request stays high across both passes
  assign o_alu_req     = (state_q != ST_IDLE);
  assign o_done        = i_alu_done & (state_q == ST_TGT);
  assign o_rsp.taken   = taken_q;
  assign o_rsp.next_pc = i_alu_result;

endmodule

/* source/exec_cluster.sv */
`timescale 1ns/1ns

module exec_cluster (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_exec_req,
  input  exec_pkg::exec_req_t   i_exec,
  output logic                  o_exec_ack,
  output exec_pkg::exec_rsp_t   o_exec_rsp,
  input  logic                  i_br_req,
  input  exec_pkg::branch_req_t i_br,
  output logic                  o_br_ack,
  output exec_pkg::branch_rsp_t o_br_rsp
);
  import exec_pkg::*;

  logic            exec_start;
  exec_req_t       exec_payload;
  logic            exec_done;
  exec_rsp_t       exec_result;
  logic            exec_alu_req;
  alu_cmd_t        exec_alu_cmd;

  logic            br_start;
  branch_req_t     br_payload;
  logic            br_done;
  branch_rsp_t     br_result;
  logic            br_alu_req;
  alu_cmd_t        br_alu_cmd;

  // client 0 is int_exec, client 1 is branch_unit
  logic [1:0]      alu_done;
  logic [XLEN-1:0] alu_result_q;
  alu_cmd_t        alu_cmd;
  logic [XLEN-1:0] alu_result;

  req_ack_port #(.payload_t(exec_req_t), .result_t(exec_rsp_t)) exec_port_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_req(i_exec_req), .i_payload(i_exec), .o_ack(o_exec_ack), .o_result(o_exec_rsp),
    .o_start(exec_start), .o_payload(exec_payload),
    .i_done(exec_done), .i_result(exec_result)
  );

  req_ack_port #(.payload_t(branch_req_t), .result_t(branch_rsp_t)) br_port_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_req(i_br_req), .i_payload(i_br), .o_ack(o_br_ack), .o_result(o_br_rsp),
    .o_start(br_start), .o_payload(br_payload),
    .i_done(br_done), .i_result(br_result)
  );

  int_exec int_exec_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_start(exec_start), .i_req(exec_payload), .o_done(exec_done), .o_rsp(exec_result),
    .o_alu_req(exec_alu_req), .o_alu_cmd(exec_alu_cmd),
    .i_alu_done(alu_done[0]), .i_alu_result(alu_result_q)
  );

  branch_unit branch_unit_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_start(br_start), .i_req(br_payload), .o_done(br_done), .o_rsp(br_result),
    .o_alu_req(br_alu_req), .o_alu_cmd(br_alu_cmd),
    .i_alu_done(alu_done[1]), .i_alu_result(alu_result_q)
  );

  alu_arbiter #(.N_CLIENTS(2)) alu_arbiter_inst (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_req({br_alu_req, exec_alu_req}), .i_cmd({br_alu_cmd, exec_alu_cmd}),
    .o_done(alu_done), .o_result(alu_result_q),
    .o_alu_cmd(alu_cmd), .i_alu_result(alu_result)
  );

  alu alu_inst (
    .i_a(alu_cmd.a), .i_b(alu_cmd.b), .i_op(alu_cmd.op), .o_result(alu_result)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // reset held over the first 5 rising edges
  initial begin
    o_arst_n = 1'b0;
    repeat (5) @(posedge o_clk);
    #1 o_arst_n = 1'b1;
  end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker #(
  parameter int N_TXN = 400
) (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_exec_req,
  input  exec_pkg::exec_req_t   i_exec,
  input  logic                  i_exec_ack,
  input  exec_pkg::exec_rsp_t   i_exec_rsp,
  input  logic                  i_br_req,
  input  exec_pkg::branch_req_t i_br,
  input  logic                  i_br_ack,
  input  exec_pkg::branch_rsp_t i_br_rsp,
  input  logic                  i_end,
  output int                    o_errors,
  output int                    o_exec_acks,
  output int                    o_br_acks
);
  import exec_pkg::*;

  int          exec_err = 0;
  int          br_err = 0;
  int          edge_err = 0;
  int          edge_cnt = 0;
  int          proto_err = 0;
  int          run_err = 0;
  int          overlap = 0;
  int          exec_acks = 0;
  int          br_acks = 0;
  logic        exec_req_q = 1'b0;
  logic        exec_ack_q = 1'b0;
  logic        exec_pend = 1'b0;
  exec_rsp_t   exec_rsp_q = '0;
  logic        br_req_q = 1'b0;
  logic        br_ack_q = 1'b0;
  logic        br_pend = 1'b0;
  branch_rsp_t br_rsp_q = '0;

  assign o_errors    = exec_err + br_err + proto_err + run_err;
  assign o_exec_acks = exec_acks;
  assign o_br_acks   = br_acks;

  // RV32I reference for OP, OP-IMM and LUI
  function automatic logic [31:0] exec_model(exec_req_t r);
    logic [4:0] shamt;
    shamt = r.b[4:0];
    if (r.kind == KIND_LUI)
      return r.b;
    case (r.funct3)
      3'd0: return (r.kind == KIND_OP && r.alt) ? r.a - r.b : r.a + r.b;
      3'd1: return r.a << shamt;
      3'd2: return {31'd0, $signed(r.a) < $signed(r.b)};
      3'd3: return {31'd0, r.a < r.b};
      3'd4: return r.a ^ r.b;
      3'd5: begin
        if (r.alt)
          return $signed(r.a) >>> shamt;
        else
          return r.a >> shamt;
      end
      3'd6: return r.a | r.b;
      default: return r.a & r.b;
    endcase
  endfunction

  function automatic logic branch_taken(branch_req_t r);
    case (r.funct3)
      3'd0: return r.rs1 == r.rs2;
      3'd1: return r.rs1 != r.rs2;
      3'd4: return $signed(r.rs1) < $signed(r.rs2);
      3'd5: return $signed(r.rs1) >= $signed(r.rs2);
      3'd6: return r.rs1 < r.rs2;
      3'd7: return r.rs1 >= r.rs2;
      default: return 1'b0;
    endcase
  endfunction

  task automatic value_error(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("ERROR at %0t: %s got %h expected %h", $time, sig, got, exp);
  endtask

  // four-phase slave rules, seen from samples at the rising edge
  task automatic check_handshake(input string port, input logic req, input logic req_q,
                                 input logic ack, input logic ack_q,
                                 input logic [32:0] rsp, input logic [32:0] rsp_q,
                                 inout logic pend);
    if (req && !req_q)
      pend = 1'b1;
    if (ack && !ack_q && !pend) begin
      $display("%s ack rose at %0t with no open request", port, $time);
      proto_err++;
    end
    if (ack_q && !ack && req_q) begin
      $display("%s ack fell at %0t while req was still high", port, $time);
      proto_err++;
    end
    if (ack_q && ack && rsp !== rsp_q) begin
      $display("%s result changed at %0t while ack was high", port, $time);
      proto_err++;
    end
  endtask

  always @(posedge i_clk) begin
    logic [31:0] exp_x;
    logic        exp_taken;
    logic [31:0] exp_pc;
    logic        edge_x;
    if (!i_arst_n) begin
      if (i_exec_ack || i_br_ack) begin
        $display("an ack was high at %0t during reset", $time);
        proto_err++;
      end
    end else begin
      check_handshake("exec", i_exec_req, exec_req_q, i_exec_ack, exec_ack_q,
                      {1'b0, i_exec_rsp}, {1'b0, exec_rsp_q}, exec_pend);
      check_handshake("branch", i_br_req, br_req_q, i_br_ack, br_ack_q,
                      i_br_rsp, br_rsp_q, br_pend);
      if (exec_pend && br_pend)
        overlap++;

      if (i_exec_ack && !exec_ack_q) begin
        exec_pend = 1'b0;
        exec_acks++;
        exp_x  = exec_model(i_exec);
        edge_x = i_exec.kind != KIND_LUI && i_exec.funct3[2:1] == 2'b01 &&
                 i_exec.a[31] != i_exec.b[31];
        if (edge_x)
          edge_cnt++;
        if (i_exec_rsp !== exp_x) begin
          value_error("o_exec_rsp", i_exec_rsp, exp_x);
          exec_err++;
          if (edge_x)
            edge_err++;
        end
        if (exec_acks == N_TXN)
          $display("exec results: %0d acks checked, %0d errors", exec_acks, exec_err);
      end

      if (i_br_ack && !br_ack_q) begin
        br_pend = 1'b0;
        br_acks++;
        exp_taken = branch_taken(i_br);
        exp_pc    = exp_taken ? i_br.pc + i_br.imm : i_br.pc + 32'd4;
        edge_x    = i_br.funct3[2] && i_br.rs1[31] != i_br.rs2[31];
        if (edge_x)
          edge_cnt++;
        if (i_br_rsp.taken !== exp_taken || i_br_rsp.next_pc !== exp_pc) begin
          value_error("o_br_rsp.taken", {31'd0, i_br_rsp.taken}, {31'd0, exp_taken});
          value_error("o_br_rsp.next_pc", i_br_rsp.next_pc, exp_pc);
          br_err++;
          if (edge_x)
            edge_err++;
        end
        if (br_acks == N_TXN)
          $display("branch results: %0d acks checked, %0d errors", br_acks, br_err);
      end
    end
    exec_req_q = i_exec_req;
    exec_ack_q = i_exec_ack;
    exec_rsp_q = i_exec_rsp;
    br_req_q   = i_br_req;
    br_ack_q   = i_br_ack;
    br_rsp_q   = i_br_rsp;
  end

  always @(posedge i_end) begin
    $display("signed and unsigned edges: %0d compares with differing signs, %0d errors",
             edge_cnt, edge_err);
    if (edge_cnt == 0) begin
      $display("no compare with differing operand signs was seen");
      run_err++;
    end
    $display("contention: %0d overlap cycles, %0d exec acks, %0d branch acks",
             overlap, exec_acks, br_acks);
    if (overlap == 0) begin
      $display("the two ports were never busy at the same time");
      run_err++;
    end
    if (exec_acks != N_TXN || br_acks != N_TXN) begin
      $display("ack count differs from the %0d requests sent per port", N_TXN);
      run_err++;
    end
    $display("protocol: %0d errors", proto_err);
  end

endmodule

/* tests/tb_exec_cluster.sv */
`timescale 1ns/1ns

module tb_exec_cluster;
  import exec_pkg::*;

  localparam int N_TXN          = 400;
  localparam int TIMEOUT_CYCLES = 2 * N_TXN * 16 + 100;

  logic        clk;
  logic        arst_n;
  logic        exec_req;
  exec_req_t   exec_pl;
  logic        exec_ack;
  exec_rsp_t   exec_rsp;
  logic        br_req;
  branch_req_t br_pl;
  logic        br_ack;
  branch_rsp_t br_rsp;
  logic        run_end = 1'b0;
  logic        exec_drv_done = 1'b0;
  logic        br_drv_done = 1'b0;
  int          errors;
  int          exec_acks;
  int          br_acks;
  int          cycles = 0;
  int          exec_seed = 32'h486ecb79;
  int          br_seed = 32'h486ecb79 + 1;

  tb_clock tb_clock_inst (.o_clk(clk), .o_arst_n(arst_n));

  exec_cluster exec_cluster_inst (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_exec_req(exec_req), .i_exec(exec_pl), .o_exec_ack(exec_ack), .o_exec_rsp(exec_rsp),
    .i_br_req(br_req), .i_br(br_pl), .o_br_ack(br_ack), .o_br_rsp(br_rsp)
  );

  tb_checker #(.N_TXN(N_TXN)) tb_checker_inst (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_exec_req(exec_req), .i_exec(exec_pl), .i_exec_ack(exec_ack), .i_exec_rsp(exec_rsp),
    .i_br_req(br_req), .i_br(br_pl), .i_br_ack(br_ack), .i_br_rsp(br_rsp),
    .i_end(run_end), .o_errors(errors), .o_exec_acks(exec_acks), .o_br_acks(br_acks)
  );

  // one time in four the operand comes from the corner list
  task automatic draw_operand(inout int seed, output logic [31:0] v);
    int sel;
    sel = $random(seed);
    if (sel[1:0] == 2'd0) begin
      case ($unsigned($random(seed)) % 5)
        0:       v = 32'h0000_0000;
        1:       v = 32'h0000_0001;
        2:       v = 32'h7fff_ffff;
        3:       v = 32'h8000_0000;
        default: v = 32'hffff_ffff;
      endcase
    end else begin
      v = $random(seed);
    end
  endtask

  task automatic exec_txn();
    logic [31:0] a;
    logic [31:0] b;
    int          raw;
    draw_operand(exec_seed, a);
    draw_operand(exec_seed, b);
    raw = $random(exec_seed);
    repeat ($unsigned($random(exec_seed)) % 4) @(posedge clk);
    #1;
    exec_pl = '{kind: exec_kind_e'(2'($unsigned(raw) % 3)), funct3: raw[4:2],
                alt: raw[5], a: a, b: b};
    exec_req = 1'b1;
    do @(posedge clk); while (!exec_ack);
    #1 exec_req = 1'b0;
    do @(posedge clk); while (exec_ack);
  endtask

  task automatic branch_txn();
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] pc;
    int          raw;
    draw_operand(br_seed, rs1);
    draw_operand(br_seed, rs2);
    raw = $random(br_seed);
    pc  = $random(br_seed);
    // force some equal operands so BEQ and BNE both see hits
    if (raw[17:16] == 2'd0)
      rs2 = rs1;
    repeat ($unsigned($random(br_seed)) % 4) @(posedge clk);
    #1;
    br_pl = '{funct3: raw[2:0], rs1: rs1, rs2: rs2, pc: {pc[31:2], 2'b00},
              imm: {{19{raw[15]}}, raw[15:4], 1'b0}};
    br_req = 1'b1;
    do @(posedge clk); while (!br_ack);
    #1 br_req = 1'b0;
    do @(posedge clk); while (br_ack);
  endtask

  initial begin
    exec_req = 1'b0;
    exec_pl  = '0;
    wait (arst_n === 1'b1);
    @(posedge clk);
    repeat (N_TXN) exec_txn();
    exec_drv_done = 1'b1;
  end

  initial begin
    br_req = 1'b0;
    br_pl  = '0;
    wait (arst_n === 1'b1);
    @(posedge clk);
    repeat (N_TXN) branch_txn();
    br_drv_done = 1'b1;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, transactions did not complete", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    wait (exec_drv_done && br_drv_done);
    @(posedge clk);
    run_end = 1'b1;
    #1;
    $display("summary: %0d exec acks, %0d branch acks, %0d errors",
             exec_acks, br_acks, errors);
    if (errors == 0 && exec_acks == N_TXN && br_acks == N_TXN)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* project.f */
source/exec_pkg.sv
source/alu.sv
source/alu_arbiter.sv
source/req_ack_port.sv
source/int_exec.sv
source/branch_unit.sv
source/exec_cluster.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_exec_cluster.sv

/* Makefile */
TOP := tb_exec_cluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir

# the pipeline status is that of grep, so a missing pass line fails the target
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
